//--- common/relay_isa_pkg.sv
// instruction-set definitions for the relay sequencer, imported by the decoder, FSM and pulse generator
package relay_isa_pkg;

	// one instruction byte as it arrives on the data bus
	typedef logic [7:0] instr_byte_t;

	// the two top opcode bits split off the mov8 and setab groups
	localparam int op_group_hi = 7;
	localparam int op_group_lo = 6;
	localparam logic [1:0] grp_mov8 = 2'b00;
	localparam logic [1:0] grp_setab = 2'b01;

	// outside those two groups the top nibble selects the class
	localparam int op_nibble_hi = 7;
	localparam int op_nibble_lo = 4;

	// class codes seen by the sequencer, which match the relay machine's decode lines
	typedef enum logic [3:0] {
		class_mov8       = 4'b0000,
		class_alu        = 4'b1000,
		class_setab      = 4'b0100,
		class_inc_xy     = 4'b1011,
		class_load_store = 4'b1001,
		class_goto       = 4'b1100,
		class_mov16_misc = 4'b1010
	} instr_class_t;

	// number of sequencer states each class occupies
	localparam int len_short = 8;
	localparam int len_medium = 12;
	localparam int len_inc = 14;
	localparam int len_long = 24;

	// maps an opcode byte onto its instruction class
	function automatic instr_class_t class_of(input instr_byte_t op);
		instr_class_t c;
		case (op[op_group_hi:op_group_lo])
			grp_mov8:  c = class_mov8;
			grp_setab: c = class_setab;
			default:
			begin
				case (op[op_nibble_hi:op_nibble_lo])
					4'b1000: c = class_alu;
					4'b1001: c = class_load_store;
					4'b1010: c = class_mov16_misc;
					4'b1011: c = class_inc_xy;
					4'b1100: c = class_goto;
					// halt and branch opcodes take the same cycle count as mov16
					default: c = class_mov16_misc;
				endcase
			end
		endcase
		return c;
	endfunction

	// gives the cycle length of a class
	function automatic int class_length(input instr_class_t c);
		int len;
		case (c)
			class_goto:                         len = len_long;
			class_inc_xy:                       len = len_inc;
			class_load_store, class_mov16_misc: len = len_medium;
			default:                            len = len_short;
		endcase
		return len;
	endfunction

endpackage

//--- common/sequencer_pkg.sv
// sequencer state and control word types, imported by every sequencer block and the top level
package sequencer_pkg;

	// the longest instruction (goto) walks through all of these states
	localparam int num_states = 24;

	// one bit per state so the state register is also the Moore output
	typedef enum logic [num_states-1:0] {
		state_1  = 24'h00_0001,
		state_2  = 24'h00_0002,
		state_3  = 24'h00_0004,
		state_4  = 24'h00_0008,
		state_5  = 24'h00_0010,
		state_6  = 24'h00_0020,
		state_7  = 24'h00_0040,
		state_8  = 24'h00_0080,
		state_9  = 24'h00_0100,
		state_10 = 24'h00_0200,
		state_11 = 24'h00_0400,
		state_12 = 24'h00_0800,
		state_13 = 24'h00_1000,
		state_14 = 24'h00_2000,
		state_15 = 24'h00_4000,
		state_16 = 24'h00_8000,
		state_17 = 24'h01_0000,
		state_18 = 24'h02_0000,
		state_19 = 24'h04_0000,
		state_20 = 24'h08_0000,
		state_21 = 24'h10_0000,
		state_22 = 24'h20_0000,
		state_23 = 24'h40_0000,
		state_24 = 24'h80_0000
	} seq_state_t;

	// the instruction register captures the data bus at the end of this state
	localparam seq_state_t ir_load_state = state_5;

	// control lines sent to the rest of the machine
	typedef struct packed {
		logic fetch_addr;
		logic mem_read;
		logic ir_load;
		logic pc_inc;
		logic execute;
		logic instr_done;
	} ctrl_word_t;

endpackage

//--- sequencer/instr_decoder.sv
// instruction register and class decode, instantiated once in the relay sequencer top level
`timescale 1ns/1ps

module instr_decoder
	import relay_isa_pkg::*;
	import sequencer_pkg::*;
(
	input  logic         clock,
	input  logic         rst_n,
	input  seq_state_t   state,
	input  instr_byte_t  data_bus,
	output instr_class_t iclass
);

	// the latched instruction byte
	instr_byte_t ir;

	// load enable comes straight from the one-hot state
	logic ir_en;

	// the bus only carries the instruction while the fetch sits in the load state
	assign ir_en = (state == ir_load_state);

	// the register is cleared so that a fresh machine decodes as mov8
	always_ff @(posedge clock or negedge rst_n)
	begin
		if (!rst_n)
			ir <= '0;
		else if (ir_en)
			ir <= data_bus;
	end

	// the class is decoded from the register and not from the bus
	// so it holds steady from state_6 until the next load, whatever the bus does meanwhile
	assign iclass = class_of(ir);

endmodule

//--- sequencer/sequence_fsm.sv
// one-hot sequence FSM that steps through the states of each instruction, used by the top level
`timescale 1ns/1ps

module sequence_fsm
	import relay_isa_pkg::*;
	import sequencer_pkg::*;
(
	input  logic         clock,
	input  logic         rst_n,
	input  instr_class_t iclass,
	output seq_state_t   state
);

	seq_state_t next_state;

	// number of states the current instruction needs
	int cur_len;

	assign cur_len = class_length(iclass);

	// reset puts the machine at the start of a fetch
	always_ff @(posedge clock or negedge rst_n)
	begin
		if (!rst_n)
			state <= state_1;
		else
			state <= next_state;
	end

	// the state simply walks forward apart from three exit points
	always_comb
	begin
		case (state)
			state_1:  next_state = state_2;
			state_2:  next_state = state_3;
			state_3:  next_state = state_4;
			state_4:  next_state = state_5;
			state_5:  next_state = state_6;
			state_6:  next_state = state_7;
			state_7:  next_state = state_8;
			// mov8, alu and setab end here
			state_8:  next_state = (cur_len == len_short) ? state_1 : state_9;
			state_9:  next_state = state_10;
			state_10: next_state = state_11;
			state_11: next_state = state_12;
			// load/store and the mov16 group end here
			state_12: next_state = (cur_len == len_medium) ? state_1 : state_13;
			state_13: next_state = state_14;
			// only inc_xy stops at 14, goto carries on to the last state
			state_14: next_state = (cur_len == len_inc) ? state_1 : state_15;
			state_15: next_state = state_16;
			state_16: next_state = state_17;
			state_17: next_state = state_18;
			state_18: next_state = state_19;
			state_19: next_state = state_20;
			state_20: next_state = state_21;
			state_21: next_state = state_22;
			state_22: next_state = state_23;
			state_23: next_state = state_24;
			state_24: next_state = state_1;
			// a corrupted code with zero or several hot bits restarts the fetch
			default:  next_state = state_1;
		endcase
	end

endmodule

//--- sequencer/control_pulse_gen.sv
// registered control word generator driven by the sequencer state, used by the top level
`timescale 1ns/1ps

module control_pulse_gen
	import relay_isa_pkg::*;
	import sequencer_pkg::*;
(
	input  logic         clock,
	input  logic         rst_n,
	input  seq_state_t   state,
	input  instr_class_t iclass,
	output ctrl_word_t   ctrl
);

	// bit position of the last state of the current instruction
	logic [4:0] final_idx;

	// the word as decoded from the present state, before the output register
	ctrl_word_t ctrl_next;

	// same length rule as the FSM so both agree on where the instruction ends
	assign final_idx = 5'(class_length(iclass) - 1);

	always_comb
	begin
		ctrl_next = '0;

		// fetch address is driven from state_1 through state_6
		ctrl_next.fetch_addr = |state[5:0];

		// memory is read from state_2 through state_5
		ctrl_next.mem_read = |state[4:1];

		ctrl_next.ir_load = (state == ir_load_state);

		// the program counter steps once the fetch is over
		ctrl_next.pc_inc = state[6];

		// execute covers state_8 up to the final state of the class
		for (int i = 7; i < num_states; i++)
		begin
			if (state[i] && (i <= int'(final_idx)))
				ctrl_next.execute = 1'b1;
		end

		// only the final state of the instruction raises done
		ctrl_next.instr_done = state[final_idx];
	end

	// the output register keeps decode glitches away from the relay drivers
	// and gives every line a fixed latency of one cycle
	always_ff @(posedge clock or negedge rst_n)
	begin
		if (!rst_n)
			ctrl <= '0;
		else
			ctrl <= ctrl_next;
	end

endmodule

//--- logic/relay_sequencer_top.sv
// top level of the relay sequencer that joins the decoder, the FSM and the pulse generator
`timescale 1ns/1ps

module relay_sequencer_top
	import relay_isa_pkg::*;
	import sequencer_pkg::*;
(
	input  logic        clock,
	input  logic        rst_n,
	input  instr_byte_t data_bus,
	output seq_state_t  state,
	output ctrl_word_t  ctrl
);

	// class of the latched instruction, shared by the FSM and the pulse generator
	instr_class_t iclass;

	instr_decoder i_decoder (
		.clock    (clock),
		.rst_n    (rst_n),
		.state    (state),
		.data_bus (data_bus),
		.iclass   (iclass)
	);

	sequence_fsm i_fsm (
		.clock  (clock),
		.rst_n  (rst_n),
		.iclass (iclass),
		.state  (state)
	);

	control_pulse_gen i_pulse_gen (
		.clock  (clock),
		.rst_n  (rst_n),
		.state  (state),
		.iclass (iclass),
		.ctrl   (ctrl)
	);

endmodule

//--- tb/sequencer_props.sv
// concurrent state checks on the sequence FSM, attached to it by a bind in the testbench
`timescale 1ns/1ps

module sequencer_props
	import relay_isa_pkg::*;
	import sequencer_pkg::*;
(
	input logic         clock,
	input logic         rst_n,
	input instr_class_t iclass,
	input seq_state_t   state
);

	// zero based index of the last state of the current class
	int last_idx;

	// every state bit above the last state of the class
	logic [num_states-1:0] beyond_last;

	function automatic int last_state_of(input instr_class_t c);
		case (c)
			class_goto:                         return 23;
			class_inc_xy:                       return 13;
			class_load_store, class_mov16_misc: return 11;
			default:                            return 7;
		endcase
	endfunction

	assign last_idx = last_state_of(iclass);
	assign beyond_last = ~((24'd1 << (last_idx + 1)) - 24'd1);

	a_one_hot: assert property (@(posedge clock) disable iff (!rst_n) $onehot(state))
		else $error("sequencer state lost its one-hot encoding");

	// the class holds from state_6 onward, so it is stable across the final state
	a_wrap: assert property (@(posedge clock) disable iff (!rst_n)
		(state == seq_state_t'(24'd1 << last_idx)) |=> (state == state_1))
		else $error("state_1 did not follow the final state of the instruction");

	a_bound: assert property (@(posedge clock) disable iff (!rst_n)
		((state & beyond_last) == '0))
		else $error("state moved past the final state of the instruction");

endmodule

//--- tb/tb_relay_sequencer.sv
// self-checking testbench for the relay sequencer, built and run by the Makefile with Verilator
`timescale 1ns/1ps

module tb_relay_sequencer
	import relay_isa_pkg::*;
	import sequencer_pkg::*;
();

	localparam int clk_period = 40;
	localparam int reset_cycles = 10;
	localparam int num_instr = 200;
	// every instruction takes at most num_states cycles, plus margin around reset and the end
	localparam int watchdog_cycles = reset_cycles + num_instr * num_states + 50;

	logic clock;
	logic rst_n;
	instr_byte_t data_bus;
	seq_state_t state;
	ctrl_word_t ctrl;

	// progress and coverage kept by the checker process
	int checked = 0;
	logic [3:0] lengths_seen = '0;
	logic folded_seen = 1'b0;

	relay_sequencer_top i_dut (
		.clock    (clock),
		.rst_n    (rst_n),
		.data_bus (data_bus),
		.state    (state),
		.ctrl     (ctrl)
	);

	bind sequence_fsm sequencer_props i_props (
		.clock  (clock),
		.rst_n  (rst_n),
		.iclass (iclass),
		.state  (state)
	);

	// the class rule looks at the top two bits first and then at the top nibble
	function automatic instr_class_t expected_class(input instr_byte_t op);
		instr_class_t c;
		if (op[7:6] == 2'b00)
			c = class_mov8;
		else if (op[7:6] == 2'b01)
			c = class_setab;
		else
		begin
			case (op[7:4])
				4'b1000: c = class_alu;
				4'b1001: c = class_load_store;
				4'b1011: c = class_inc_xy;
				4'b1100: c = class_goto;
				// 1010 and the halt and branch group 1101 to 1111
				default: c = class_mov16_misc;
			endcase
		end
		return c;
	endfunction

	function automatic int expected_length(input instr_class_t c);
		case (c)
			class_goto:                         return 24;
			class_inc_xy:                       return 14;
			class_load_store, class_mov16_misc: return 12;
			default:                            return 8;
		endcase
	endfunction

	// word for a state given by its zero based index, where -1 stands for no state yet
	function automatic ctrl_word_t expected_ctrl(input int idx, input instr_class_t c);
		ctrl_word_t w;
		int last;
		w = '0;
		last = expected_length(c) - 1;
		if (idx >= 0)
		begin
			w.fetch_addr = (idx <= 5);
			w.mem_read = (idx >= 1 && idx <= 4);
			w.ir_load = (idx == 4);
			w.pc_inc = (idx == 6);
			w.execute = (idx >= 7 && idx <= last);
			w.instr_done = (idx == last);
		end
		return w;
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("*** TEST FAILED ***");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_state(input seq_state_t got, input seq_state_t exp);
		if (got !== exp)
			abort_run($sformatf("ERROR at %0t ns: state %h, expected %h", $time, got, exp));
	endtask

	task automatic check_ctrl(input ctrl_word_t got, input ctrl_word_t exp);
		if (got !== exp)
			abort_run($sformatf("ERROR at %0t ns: ctrl %b, expected %b", $time, got, exp));
	endtask

	task automatic check_length(input int got, input int exp);
		if (got != exp)
			abort_run($sformatf("ERROR at %0t ns: instruction took %0d cycles, expected %0d",
				$time, got, exp));
	endtask

	initial
	begin
		clock = 1'b0;
		forever
			#(clk_period / 2) clock = ~clock;
	end

	initial
	begin
		#(watchdog_cycles * clk_period);
		abort_run("watchdog expired before all instructions were checked");
	end

	// the instruction byte goes out at state_5 and noise in every other state
	initial
	begin
		int issued;
		void'($urandom(66));
		issued = 0;
		rst_n = 1'b0;
		data_bus = '0;
		repeat (reset_cycles) @(negedge clock);
		check_state(state, state_1);
		check_ctrl(ctrl, '0);
		rst_n = 1'b1;
		while (issued < num_instr)
		begin
			@(negedge clock);
			data_bus = 8'($urandom);
			if (state == state_5)
				issued++;
		end
		wait (checked >= num_instr);
		@(negedge clock);
		if (lengths_seen == 4'b1111 && folded_seen)
		begin
			$display("*** TEST PASSED ***");
			$finish;
		end
		else
			abort_run("the random stream missed an instruction length or the folded opcodes");
	end

	// the checker reads at each rising edge the values held through the cycle just ended
	initial
	begin
		int exp_idx;
		int prev_idx;
		int cycles;
		int dones;
		instr_class_t cur_class;
		exp_idx = 0;
		prev_idx = -1;
		cycles = 0;
		dones = 0;
		cur_class = class_mov8;
		@(posedge rst_n);
		forever
		begin
			@(posedge clock);
			// ctrl lags the state by one cycle
			check_ctrl(ctrl, expected_ctrl(prev_idx, cur_class));
			if (ctrl.instr_done)
				dones++;
			// the length is measured up to the DUT's own return to state_1
			if (state == state_1 && cycles > 0)
			begin
				check_length(cycles, expected_length(cur_class));
				if (dones != 1)
					abort_run("instr_done did not pulse exactly once for an instruction");
				case (expected_length(cur_class))
					8:       lengths_seen[0] = 1'b1;
					12:      lengths_seen[1] = 1'b1;
					14:      lengths_seen[2] = 1'b1;
					default: lengths_seen[3] = 1'b1;
				endcase
				checked++;
				cycles = 0;
				dones = 0;
			end
			check_state(state, seq_state_t'(24'd1 << exp_idx));
			// the byte on the bus now is the one the instruction register takes
			if (exp_idx == 4)
			begin
				cur_class = expected_class(data_bus);
				if (data_bus[7:4] >= 4'hd)
					folded_seen = 1'b1;
			end
			cycles++;
			prev_idx = exp_idx;
			if (exp_idx == expected_length(cur_class) - 1)
				exp_idx = 0;
			else
				exp_idx++;
		end
	end

endmodule

//--- filelist.f
common/relay_isa_pkg.sv
common/sequencer_pkg.sv
sequencer/instr_decoder.sv
sequencer/sequence_fsm.sv
sequencer/control_pulse_gen.sv
logic/relay_sequencer_top.sv
tb/sequencer_props.sv
tb/tb_relay_sequencer.sv

//--- Makefile
SRCS := $(wildcard common/*.sv sequencer/*.sv logic/*.sv tb/*.sv)

obj_dir/Vtb_relay_sequencer: filelist.f $(SRCS)
	verilator --binary --timing --assert -j 0 -f filelist.f --top-module tb_relay_sequencer

run: obj_dir/Vtb_relay_sequencer
	./obj_dir/Vtb_relay_sequencer

clean:
	rm -rf obj_dir

.PHONY: run clean
